//--- vsmul_pkg.sv
// Shared types, AXI4-Lite constants and register map for the vsmul accelerator and its testbench
`default_nettype none

package vsmul_pkg;

    // ====================
    // Bus widths and responses
    // ====================
    localparam int         AXI_DATA_W  = 32;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ====================
    // Datapath types
    // ====================
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    typedef enum logic [1:0] {
        RNU_V = 2'd0,    // Round to nearest, ties up
        RNE_V = 2'd1,    // Round to nearest, ties to even
        RDN_V = 2'd2,    // Truncate
        ROD_V = 2'd3     // Jam into the lsb
    } vxrm_t;

    typedef logic [63:0]  bus64_t;
    typedef logic [127:0] bus128_t;    // Product vector, element k at 2*SEW*k

    typedef struct packed {
        sew_t   sew;
        vxrm_t  vxrm;
        bus64_t vs1;
        bus64_t vs2;
    } vsmul_op_t;

    typedef struct packed {
        bus64_t vd;
        logic   sat;                   // Some element saturated
    } vsmul_res_t;

    // ====================
    // Register map
    // ====================
    typedef enum logic [7:0] {
        REG_VS1_LO = 8'h00,
        REG_VS1_HI = 8'h04,
        REG_VS2_LO = 8'h08,
        REG_VS2_HI = 8'h0C,
        REG_CTRL   = 8'h10,    // sew[1:0], vxrm[3:2], start[4]
        REG_STATUS = 8'h14,    // busy[0], done[1], vxsat[2]
        REG_RES_LO = 8'h18,
        REG_RES_HI = 8'h1C
    } reg_addr_e;

    localparam int CTRL_START_BIT   = 4;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_DONE_BIT  = 1;
    localparam int STATUS_VXSAT_BIT = 2;

    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_MUL  = 2'd1,    // op_valid out to the multiplier
        CTRL_SAT  = 2'd2     // Products at vsmul, result captured
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- vmul_lanes.sv
// Registered SIMD signed multiplier producing double-width products for the vsmul stage
`default_nettype none

module vmul_lanes
    import vsmul_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  vsmul_op_t op_i,
    input  logic      op_valid_i,
    output bus128_t   prod_o,
    output sew_t      sew_o,
    output vxrm_t     vxrm_o,
    output logic      prod_valid_o
);

    bus128_t prod_d;

    // ====================
    // Per-width products
    // ====================
    always_comb begin
        prod_d = '0;
        case (op_i.sew)
            SEW_8: begin
                for (int k = 0; k < 8; k++) begin
                    prod_d[16*k +: 16] = 16'($signed(op_i.vs1[8*k +: 8]))
                                       * 16'($signed(op_i.vs2[8*k +: 8]));
                end
            end
            SEW_16: begin
                for (int k = 0; k < 4; k++) begin
                    prod_d[32*k +: 32] = 32'($signed(op_i.vs1[16*k +: 16]))
                                       * 32'($signed(op_i.vs2[16*k +: 16]));
                end
            end
            SEW_32: begin
                for (int k = 0; k < 2; k++) begin
                    prod_d[64*k +: 64] = 64'($signed(op_i.vs1[32*k +: 32]))
                                       * 64'($signed(op_i.vs2[32*k +: 32]));
                end
            end
            SEW_64: begin
                prod_d = 128'($signed(op_i.vs1)) * 128'($signed(op_i.vs2));
            end
            default: prod_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prod_valid_o <= 1'b0;
        end else begin
            prod_valid_o <= op_valid_i;
        end
    end

    // Width and mode travel with the products
    always_ff @(posedge clk_i) begin
        if (op_valid_i) begin
            prod_o <= prod_d;
            sew_o  <= op_i.sew;
            vxrm_o <= op_i.vxrm;
        end
    end

    a_prod_follows_op: assert property (@(posedge clk_i) disable iff (reset_i)
        prod_valid_o == $past(op_valid_i))
        else $error("prod_valid did not follow op_valid by one cycle");

endmodule

`default_nettype wire

//--- vsmul.sv
// Combinational shift, rounding and saturation of a product vector into SEW-bit results
`default_nettype none

module vsmul
    import vsmul_pkg::*;
(
    input  sew_t    sew_i,
    input  vxrm_t   vxrm_i,
    input  bus128_t data_i,       // Products from vmul_lanes
    output bus64_t  data_vd_o,
    output logic    sat_ovf_o     // Any element saturated
);

    logic [7:0][7:0] shifted;     // Bits 2*SEW-2 .. SEW-1 of each product
    logic [7:0][7:0] sum;
    logic [7:0]      inc;         // Rounding increment at element low byte
    logic [7:0]      top_sign;    // Product sign at element top byte
    logic [7:0]      elem_lo;     // Byte opens an element, carry cut here
    logic [7:0]      elem_hi;     // Byte closes an element
    logic [7:0]      ovf;

    // lsb is result bit SEW-1, half is bit SEW-2, rest is OR of bits SEW-3..0
    function automatic logic round_inc(input vxrm_t mode, input logic lsb,
                                       input logic half, input logic rest);
        logic r;
        case (mode)
            RNU_V:   r = half;
            RNE_V:   r = half & (rest | lsb);
            RDN_V:   r = 1'b0;
            ROD_V:   r = ~lsb & (half | rest);
            default: r = 1'b0;
        endcase
        return r;
    endfunction

    // ====================
    // Shift and increment
    // ====================
    always_comb begin
        shifted  = '0;
        inc      = '0;
        top_sign = '0;
        elem_lo  = 8'hFF;
        elem_hi  = 8'hFF;
        case (sew_i)
            SEW_8: begin
                for (int k = 0; k < 8; k++) begin
                    shifted[k]  = data_i[16*k+7 +: 8];
                    inc[k]      = round_inc(vxrm_i, data_i[16*k+7], data_i[16*k+6],
                                            |data_i[16*k +: 6]);
                    top_sign[k] = data_i[16*k+15];
                end
            end
            SEW_16: begin
                elem_lo = 8'h55;
                elem_hi = 8'hAA;
                for (int k = 0; k < 4; k++) begin
                    shifted[2*k +: 2] = data_i[32*k+15 +: 16];
                    inc[2*k]          = round_inc(vxrm_i, data_i[32*k+15], data_i[32*k+14],
                                                  |data_i[32*k +: 14]);
                    top_sign[2*k+1]   = data_i[32*k+31];
                end
            end
            SEW_32: begin
                elem_lo = 8'h11;
                elem_hi = 8'h88;
                for (int k = 0; k < 2; k++) begin
                    shifted[4*k +: 4] = data_i[64*k+31 +: 32];
                    inc[4*k]          = round_inc(vxrm_i, data_i[64*k+31], data_i[64*k+30],
                                                  |data_i[64*k +: 30]);
                    top_sign[4*k+3]   = data_i[64*k+63];
                end
            end
            SEW_64: begin
                elem_lo     = 8'h01;
                elem_hi     = 8'h80;
                shifted     = data_i[63 +: 64];
                inc[0]      = round_inc(vxrm_i, data_i[63], data_i[62], |data_i[61:0]);
                top_sign[7] = data_i[127];
            end
            default: ;
        endcase
    end

    // Byte adders, carry ripples only inside an element
    always_comb begin : add_chain
        logic carry;
        logic cin;
        carry = 1'b0;
        for (int i = 0; i < 8; i++) begin
            cin = elem_lo[i] ? 1'b0 : carry;
            {carry, sum[i]} = {1'b0, shifted[i]} + {8'b0, inc[i]} + {8'b0, cin};
        end
    end

    // Dropped sign bit disagrees with kept msb, or rounding wrapped 0x7F..F
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            ovf[i] = elem_hi[i] & ((top_sign[i] ^ shifted[i][7]) | (~shifted[i][7] & sum[i][7]));
        end
    end

    // ====================
    // Saturation
    // ====================
    always_comb begin
        data_vd_o = sum;
        case (sew_i)
            SEW_8: begin
                for (int k = 0; k < 8; k++) begin
                    data_vd_o[8*k +: 8] = ovf[k] ? 8'h7F : sum[k];
                end
            end
            SEW_16: begin
                for (int k = 0; k < 4; k++) begin
                    data_vd_o[16*k +: 16] = ovf[2*k+1] ? 16'h7FFF : sum[2*k +: 2];
                end
            end
            SEW_32: begin
                for (int k = 0; k < 2; k++) begin
                    data_vd_o[32*k +: 32] = ovf[4*k+3] ? 32'h7FFF_FFFF : sum[4*k +: 4];
                end
            end
            SEW_64: data_vd_o = ovf[7] ? 64'h7FFF_FFFF_FFFF_FFFF : sum;
            default: ;
        endcase
    end

    assign sat_ovf_o = |ovf;    // ovf is already masked to top bytes

endmodule

`default_nettype wire

//--- vsmul_ctrl.sv
// AXI4-Lite register slave that sequences one vsmul operation and holds result and status
`default_nettype none

module vsmul_ctrl
    import vsmul_pkg::*;
#(
    parameter int AXI_ADDR_W = 8
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic [AXI_ADDR_W-1:0]   s_awaddr_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [AXI_DATA_W-1:0]   s_wdata_i,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    output logic [1:0]              s_bresp_o,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    input  logic [AXI_ADDR_W-1:0]   s_araddr_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    output logic [AXI_DATA_W-1:0]   s_rdata_o,
    output logic [1:0]              s_rresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i,
    output vsmul_op_t               op_o,
    output logic                    op_valid_o,
    input  logic                    prod_valid_i,
    input  vsmul_res_t              res_i
);

    ctrl_state_e           state_q;
    vsmul_op_t             op_q;
    logic                  op_valid_q;
    bus64_t                res_q;
    logic                  done_q, vxsat_q;
    logic                  bvalid_q, rvalid_q;
    logic [1:0]            bresp_q, rresp_q;
    logic [AXI_DATA_W-1:0] rdata_q, rdata_d;
    logic                  wr_fire, rd_fire, wr_en, busy;
    logic                  start_req, status_clr, capture;

    function automatic logic addr_hit(input logic [AXI_ADDR_W-1:0] addr);
        logic hit;
        case (addr)
            AXI_ADDR_W'(REG_VS1_LO), AXI_ADDR_W'(REG_VS1_HI),
            AXI_ADDR_W'(REG_VS2_LO), AXI_ADDR_W'(REG_VS2_HI),
            AXI_ADDR_W'(REG_CTRL),   AXI_ADDR_W'(REG_STATUS),
            AXI_ADDR_W'(REG_RES_LO), AXI_ADDR_W'(REG_RES_HI): hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    // ====================
    // Handshakes
    // ====================
    assign wr_fire     = s_awvalid_i & s_wvalid_i & ~bvalid_q;   // AW and W taken together
    assign rd_fire     = s_arvalid_i & ~rvalid_q;
    assign s_awready_o = wr_fire;
    assign s_wready_o  = wr_fire;
    assign s_arready_o = rd_fire;
    assign wr_en       = wr_fire & (|s_wstrb_i);    // Any strobe writes the full word

    assign busy       = (state_q != CTRL_IDLE);
    assign start_req  = wr_en & (s_awaddr_i == AXI_ADDR_W'(REG_CTRL))
                      & s_wdata_i[CTRL_START_BIT] & ~busy;
    assign status_clr = wr_en & (s_awaddr_i == AXI_ADDR_W'(REG_STATUS));
    assign capture    = prod_valid_i & (state_q == CTRL_SAT);

    always_comb begin
        rdata_d = '0;
        case (s_araddr_i)
            AXI_ADDR_W'(REG_VS1_LO): rdata_d = op_q.vs1[31:0];
            AXI_ADDR_W'(REG_VS1_HI): rdata_d = op_q.vs1[63:32];
            AXI_ADDR_W'(REG_VS2_LO): rdata_d = op_q.vs2[31:0];
            AXI_ADDR_W'(REG_VS2_HI): rdata_d = op_q.vs2[63:32];
            AXI_ADDR_W'(REG_CTRL):   rdata_d[3:0] = {op_q.vxrm, op_q.sew};    // start reads 0
            AXI_ADDR_W'(REG_STATUS): begin
                rdata_d[STATUS_BUSY_BIT]  = busy;
                rdata_d[STATUS_DONE_BIT]  = done_q;
                rdata_d[STATUS_VXSAT_BIT] = vxsat_q;
            end
            AXI_ADDR_W'(REG_RES_LO): rdata_d = res_q[31:0];
            AXI_ADDR_W'(REG_RES_HI): rdata_d = res_q[63:32];
            default: rdata_d = '0;
        endcase
    end

    // ====================
    // Registers and FSM
    // ====================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= CTRL_IDLE;
            op_q       <= '0;
            op_valid_q <= 1'b0;
            res_q      <= '0;
            done_q     <= 1'b0;
            vxsat_q    <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            op_valid_q <= start_req;    // One-cycle pulse
            case (state_q)
                CTRL_IDLE: if (start_req) state_q <= CTRL_MUL;
                CTRL_MUL:  state_q <= CTRL_SAT;
                CTRL_SAT:  if (prod_valid_i) state_q <= CTRL_IDLE;
                default:   state_q <= CTRL_IDLE;
            endcase
            if (wr_en) begin
                case (s_awaddr_i)
                    AXI_ADDR_W'(REG_VS1_LO): op_q.vs1[31:0]  <= s_wdata_i;
                    AXI_ADDR_W'(REG_VS1_HI): op_q.vs1[63:32] <= s_wdata_i;
                    AXI_ADDR_W'(REG_VS2_LO): op_q.vs2[31:0]  <= s_wdata_i;
                    AXI_ADDR_W'(REG_VS2_HI): op_q.vs2[63:32] <= s_wdata_i;
                    AXI_ADDR_W'(REG_CTRL): begin
                        if (!(busy && s_wdata_i[CTRL_START_BIT])) begin    // Start while busy is dropped
                            op_q.sew  <= sew_t'(s_wdata_i[1:0]);
                            op_q.vxrm <= vxrm_t'(s_wdata_i[3:2]);
                        end
                    end
                    default: ;
                endcase
            end
            if (status_clr || start_req) done_q <= 1'b0;
            if (status_clr) vxsat_q <= 1'b0;
            if (capture) begin
                res_q  <= res_i.vd;
                done_q <= 1'b1;
                if (res_i.sat) vxsat_q <= 1'b1;    // Sticky until STATUS write
            end
            if (wr_fire) bvalid_q <= 1'b1;
            else if (s_bready_i) bvalid_q <= 1'b0;
            if (rd_fire) rvalid_q <= 1'b1;
            else if (s_rready_i) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) bresp_q <= addr_hit(s_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
        if (rd_fire) begin
            rdata_q <= rdata_d;
            rresp_q <= addr_hit(s_araddr_i) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign s_bvalid_o = bvalid_q;
    assign s_bresp_o  = bresp_q;
    assign s_rvalid_o = rvalid_q;
    assign s_rdata_o  = rdata_q;
    assign s_rresp_o  = rresp_q;
    assign op_o       = op_q;
    assign op_valid_o = op_valid_q;

    a_op_from_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        op_valid_o |-> $past(state_q) == CTRL_IDLE)
        else $error("op_valid raised outside CTRL_IDLE");

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o)
        else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

//--- vsmul_unit_top.sv
// Top level of the vsmul accelerator joining the AXI4-Lite controller to the datapath
`default_nettype none

module vsmul_unit_top
    import vsmul_pkg::*;
#(
    parameter int AXI_ADDR_W = 8
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic [AXI_ADDR_W-1:0]   s_awaddr_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [AXI_DATA_W-1:0]   s_wdata_i,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    output logic [1:0]              s_bresp_o,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    input  logic [AXI_ADDR_W-1:0]   s_araddr_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    output logic [AXI_DATA_W-1:0]   s_rdata_o,
    output logic [1:0]              s_rresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i
);

    vsmul_op_t       op;
    logic            op_valid;
    bus128_t         prod;
    sew_t            sew;
    vxrm_t           vxrm;
    logic            prod_valid;
    wire vsmul_res_t res;    // Assembled from the two vsmul outputs

    vsmul_ctrl #(
        .AXI_ADDR_W (AXI_ADDR_W)
    ) i_vsmul_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .s_awaddr_i   (s_awaddr_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wstrb_i    (s_wstrb_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_bresp_o    (s_bresp_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_araddr_i   (s_araddr_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .op_o         (op),
        .op_valid_o   (op_valid),
        .prod_valid_i (prod_valid),
        .res_i        (res)
    );

    vmul_lanes i_vmul_lanes (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .op_i         (op),
        .op_valid_i   (op_valid),
        .prod_o       (prod),
        .sew_o        (sew),
        .vxrm_o       (vxrm),
        .prod_valid_o (prod_valid)
    );

    vsmul i_vsmul (
        .sew_i     (sew),
        .vxrm_i    (vxrm),
        .data_i    (prod),
        .data_vd_o (res.vd),
        .sat_ovf_o (res.sat)
    );

endmodule

`default_nettype wire

//--- tb_vsmul_unit.sv
// Self-checking testbench for vsmul_unit_top, built from compile.f and run by run_sim.sh
`default_nettype none

module tb_vsmul_unit
    import vsmul_pkg::*;
();

    localparam int TIMEOUT = 50;    // Cycles per handshake wait, polls per done wait

    logic        clk_i;
    logic        reset_i;
    logic [7:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic [3:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [7:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;

    int          errors;
    int          checks;
    logic [31:0] lfsr_q;
    logic [63:0] round_exp [4];    // Hand-worked results of the rounding vector, one per mode

    vsmul_unit_top #(
        .AXI_ADDR_W (8)
    ) i_vsmul_unit_top (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_wdata_i   (s_wdata),
        .s_wstrb_i   (s_wstrb),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_bresp_o   (s_bresp),
        .s_bvalid_o  (s_bvalid),
        .s_bready_i  (s_bready),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rresp_o   (s_rresp),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ====================
    // Response hold checks
    // ====================
    a_write_held: assert property (@(posedge clk_i) disable iff (reset_i)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
        else begin
            $display("** Error at %0t: write response changed while bready was low", $time);
            errors++;
        end

    a_read_held: assert property (@(posedge clk_i) disable iff (reset_i)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
        else begin
            $display("** Error at %0t: read response changed while rready was low", $time);
            errors++;
        end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Galois LFSR, one step per random bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [63:0] random64();
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < 64; i++) begin
            v = {v[62:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] ctrl_word(input sew_t sew, input vxrm_t vxrm);
        return {27'b0, 1'b1, vxrm, sew};    // Start bit set
    endfunction

    // Returns {vd, sat}: product shifted right by SEW-1, rounded, clamped to SEW bits
    function automatic logic [64:0] ref_vsmul(input sew_t sew, input vxrm_t vxrm,
                                              input logic [63:0] a, input logic [63:0] b);
        int                  w;
        logic signed [127:0] ea, eb, p, q, maxv;
        logic                lsb, half, rest, inc, sat;
        logic [63:0]         elem, vd;
        w    = 8 << sew;
        vd   = '0;
        sat  = 1'b0;
        maxv = (128'sd1 <<< (w - 1)) - 128'sd1;
        for (int k = 0; k < 64 / w; k++) begin
            ea   = $signed({64'b0, a >> (w * k)});
            eb   = $signed({64'b0, b >> (w * k)});
            ea   = (ea <<< (128 - w)) >>> (128 - w);    // Sign-extend the element
            eb   = (eb <<< (128 - w)) >>> (128 - w);
            p    = ea * eb;
            lsb  = p[w - 1];
            half = p[w - 2];
            rest = (p << (130 - w)) != 0;               // Any of bits SEW-3..0
            case (vxrm)
                RNU_V:   inc = half;
                RNE_V:   inc = half & (rest | lsb);
                ROD_V:   inc = ~lsb & (half | rest);
                default: inc = 1'b0;
            endcase
            q = (p >>> (w - 1)) + $signed({127'b0, inc});
            if (q > maxv) begin
                q   = maxv;
                sat = 1'b1;
            end
            elem = q[63:0];
            if (w < 64) begin
                elem = elem & ((64'd1 << w) - 64'd1);
            end
            vd = vd | (elem << (w * k));
        end
        return {vd, sat};
    endfunction

    // ====================
    // AXI4-Lite accesses
    // ====================
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input int hold,
                             input logic [1:0] exp_resp);
        int cycles;
        s_awaddr  <= addr;
        s_wdata   <= data;
        s_awvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!(s_awready && s_wready) && cycles < TIMEOUT);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        if (!(s_awready && s_wready)) begin
            $display("Write to address %h was never accepted", addr);
            errors++;
            return;
        end
        cycles = 0;
        while (!s_bvalid && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!s_bvalid) begin
            $display("No write response came for address %h", addr);
            errors++;
            return;
        end
        repeat (hold) @(posedge clk_i);    // Back-pressure on B
        s_bready <= 1'b1;
        @(posedge clk_i);
        check_value($sformatf("write response at %h", addr), 64'(s_bresp), 64'(exp_resp));
        s_bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, input int hold, input logic [1:0] exp_resp,
                            output logic [31:0] data);
        int cycles;
        data      = '0;
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!s_arready && cycles < TIMEOUT);
        s_arvalid <= 1'b0;
        if (!s_arready) begin
            $display("Read of address %h was never accepted", addr);
            errors++;
            return;
        end
        cycles = 0;
        while (!s_rvalid && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!s_rvalid) begin
            $display("No read data came for address %h", addr);
            errors++;
            return;
        end
        repeat (hold) @(posedge clk_i);    // Back-pressure on R
        s_rready <= 1'b1;
        @(posedge clk_i);
        data = s_rdata;
        check_value($sformatf("read response at %h", addr), 64'(s_rresp), 64'(exp_resp));
        s_rready <= 1'b0;
    endtask

    task automatic load_operands(input logic [63:0] a, input logic [63:0] b);
        write_reg(REG_VS1_LO, a[31:0], 0, RESP_OKAY);
        write_reg(REG_VS1_HI, a[63:32], 0, RESP_OKAY);
        write_reg(REG_VS2_LO, b[31:0], 0, RESP_OKAY);
        write_reg(REG_VS2_HI, b[63:32], 0, RESP_OKAY);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            read_reg(REG_STATUS, 0, RESP_OKAY, status);
            polls++;
        end while (!status[STATUS_DONE_BIT] && polls < TIMEOUT);
        if (!status[STATUS_DONE_BIT]) begin
            $display("Operation never reported done");
            errors++;
        end
    endtask

    task automatic read_result(output logic [63:0] vd);
        logic [31:0] lo, hi;
        read_reg(REG_RES_LO, 0, RESP_OKAY, lo);
        read_reg(REG_RES_HI, 0, RESP_OKAY, hi);
        vd = {hi, lo};
    endtask

    task automatic run_op(input sew_t sew, input vxrm_t vxrm, input logic [63:0] a,
                          input logic [63:0] b, output logic [63:0] vd);
        logic [64:0] ref_res;
        load_operands(a, b);
        write_reg(REG_CTRL, ctrl_word(sew, vxrm), 0, RESP_OKAY);
        wait_done();
        read_result(vd);
        ref_res = ref_vsmul(sew, vxrm, a, b);
        check_value($sformatf("result sew %0d vxrm %0d", sew, vxrm), vd, ref_res[64:1]);
    endtask

    // Second CTRL write lands while the first operation is still busy
    task automatic start_twice(input logic [31:0] first, input logic [31:0] second);
        int cycles;
        s_awaddr  <= REG_CTRL;
        s_wdata   <= first;
        s_awvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        s_bready  <= 1'b1;
        for (int n = 0; n < 2; n++) begin
            cycles = 0;
            do begin
                @(posedge clk_i);
                cycles++;
            end while (!(s_awready && s_wready) && cycles < TIMEOUT);
            if (!(s_awready && s_wready)) begin
                $display("Back-to-back CTRL write %0d was never accepted", n);
                errors++;
            end
            s_wdata <= second;
        end
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!s_bvalid && cycles < TIMEOUT);
        if (!s_bvalid) begin
            $display("No write response came for the second start");
            errors++;
        end
        check_value("second start response", 64'(s_bresp), 64'(RESP_OKAY));
        s_bready <= 1'b0;
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        logic [63:0] a, b, vd, minneg;
        logic [64:0] ref_res;
        logic [31:0] rd0, rd1;
        int          w;
        errors       = 0;
        checks       = 0;
        lfsr_q       = 32'h22f4;
        reset_i      = 1'b1;
        s_awaddr     = '0;
        s_awvalid    = 1'b0;
        s_wdata      = '0;
        s_wstrb      = 4'hF;
        s_wvalid     = 1'b0;
        s_bready     = 1'b0;
        s_araddr     = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b0;
        round_exp[0] = 64'h007E_0000_0001_0201;    // RNU
        round_exp[1] = 64'h007E_0000_0001_0200;    // RNE
        round_exp[2] = 64'hFF7E_00FF_0000_0100;    // RDN
        round_exp[3] = 64'hFF7F_00FF_0101_0101;    // ROD
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);

        // Reset values, then operand readback
        read_reg(REG_STATUS, 0, RESP_OKAY, rd0);
        check_value("STATUS after reset", 64'(rd0), 64'h0);
        read_reg(REG_RES_LO, 0, RESP_OKAY, rd0);
        check_value("RES_LO after reset", 64'(rd0), 64'h0);
        read_reg(REG_RES_HI, 0, RESP_OKAY, rd0);
        check_value("RES_HI after reset", 64'(rd0), 64'h0);
        a = random64();
        b = random64();
        load_operands(a, b);
        read_reg(REG_VS1_LO, 0, RESP_OKAY, rd0);
        check_value("VS1_LO readback", 64'(rd0), 64'(a[31:0]));
        read_reg(REG_VS1_HI, 0, RESP_OKAY, rd0);
        check_value("VS1_HI readback", 64'(rd0), 64'(a[63:32]));
        read_reg(REG_VS2_LO, 0, RESP_OKAY, rd0);
        check_value("VS2_LO readback", 64'(rd0), 64'(b[31:0]));
        read_reg(REG_VS2_HI, 0, RESP_OKAY, rd0);
        check_value("VS2_HI readback", 64'(rd0), 64'(b[63:32]));

        // Random operands over every width and mode
        for (int s = 0; s < 4; s++) begin
            for (int m = 0; m < 4; m++) begin
                for (int r = 0; r < 2; r++) begin
                    a = random64();
                    b = random64();
                    run_op(sew_t'(s), vxrm_t'(m), a, b, vd);
                end
            end
        end

        // Most negative times most negative saturates, vxsat is sticky
        for (int s = 0; s < 4; s++) begin
            w      = 8 << s;
            minneg = '0;
            for (int k = 0; k < 64 / w; k++) begin
                minneg = minneg | (64'd1 << (w * k + w - 1));
            end
            write_reg(REG_STATUS, 32'h0, 0, RESP_OKAY);    // Each width must set vxsat itself
            run_op(sew_t'(s), RNU_V, minneg, minneg, vd);
            ref_res = ref_vsmul(sew_t'(s), RNU_V, minneg, minneg);
            check_value($sformatf("saturated result sew %0d", s), vd, ~minneg);
            read_reg(REG_STATUS, 0, RESP_OKAY, rd0);
            check_value("vxsat after saturation", 64'(rd0[STATUS_VXSAT_BIT]), 64'(ref_res[0]));
        end
        run_op(SEW_16, RNE_V, 64'h0003_0002_0001_0004, 64'h0100_0200_0300_0400, vd);
        read_reg(REG_STATUS, 0, RESP_OKAY, rd0);
        check_value("vxsat after plain operation", 64'(rd0[STATUS_VXSAT_BIT]), 64'h1);
        write_reg(REG_STATUS, 32'h0, 0, RESP_OKAY);
        read_reg(REG_STATUS, 0, RESP_OKAY, rd0);
        check_value("STATUS after clear", 64'(rd0), 64'h0);

        // Ties, above half and below half in each byte lane
        for (int m = 0; m < 4; m++) begin
            run_op(SEW_8, vxrm_t'(m), 64'hFF7F_00F8_0705_0C08, 64'h017F_0008_090D_1008, vd);
            check_value($sformatf("rounding vector mode %0d", m), vd, round_exp[m]);
        end

        // Unmapped address and held responses
        read_reg(8'h20, 0, RESP_SLVERR, rd0);
        write_reg(8'h20, 32'hDEAD_BEEF, 0, RESP_SLVERR);
        read_reg(REG_RES_LO, 0, RESP_OKAY, rd0);
        read_reg(REG_RES_LO, 6, RESP_OKAY, rd1);
        check_value("RES_LO with rready held low", 64'(rd1), 64'(rd0));
        write_reg(REG_VS1_LO, 32'h1234_5678, 5, RESP_OKAY);
        read_reg(REG_VS1_LO, 4, RESP_OKAY, rd0);
        check_value("VS1_LO after held write", 64'(rd0), 64'h1234_5678);

        // A start while busy must not replace the running operation
        a = random64();
        b = random64();
        load_operands(a, b);
        start_twice(ctrl_word(SEW_8, RNU_V), ctrl_word(SEW_16, ROD_V));
        wait_done();
        read_result(vd);
        ref_res = ref_vsmul(SEW_8, RNU_V, a, b);
        check_value("result after ignored start", vd, ref_res[64:1]);
        read_reg(REG_CTRL, 0, RESP_OKAY, rd0);
        check_value("CTRL after ignored start", 64'(rd0),
                    64'(ctrl_word(SEW_8, RNU_V) & ~(32'd1 << CTRL_START_BIT)));

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
vsmul_pkg.sv
vmul_lanes.sv
vsmul.sv
vsmul_ctrl.sv
vsmul_unit_top.sv
tb_vsmul_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build the vsmul testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_vsmul_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_vsmul_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
